//--- verilog/fabric_config.svh
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

`default_nettype none

// the fabric is one row of tiles with a left-to-right channel
`define FAB_TILES         4
`define FAB_TRACKS        4
`define FAB_PINS_PER_TILE 2
`define FAB_PINS          (`FAB_TILES * `FAB_PINS_PER_TILE)
`define FAB_TILE_BITS     41                            // one tile word in the chain
`define FAB_CFG_BITS      (`FAB_TILES * `FAB_TILE_BITS) // 164 bits in total

// field offsets inside one tile word
`define CFG_CB_LSB    0  // two select bits per CLB input
`define CFG_SB_LSB    8  // two select bits per outgoing track
`define CFG_IO_LSB    16 // per pin the oe bit, then a two-bit track select
`define CFG_MODE_BIT  22 // set for one LUT4, clear for two LUT3
`define CFG_REG1_BIT  23
`define CFG_REG2_BIT  24
`define CFG_TABLE_LSB 25
`define CFG_TABLE_W   16

// switch box select codes
`define SB_PASS 2'd0 // pass the incoming track straight on
`define SB_Y1   2'd1
`define SB_Y2   2'd2
`define SB_PIN  2'd3 // even tracks take the even pin, odd tracks the odd pin

`default_nettype wire

`endif

//--- verilog/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

	// the 16-bit truth table of one CLB, read either as a whole
	// or as two independent 8-entry tables
	typedef union packed {
		logic [15:0]      lut4;   // LUT4 mode, indexed by all four inputs
		logic [1:0][7:0]  halves; // dual mode, one byte per LUT3
	} clb_table_u;

	// which byte of halves feeds which output
	localparam int unsigned TBL_LO = 0; // lower byte drives y1
	localparam int unsigned TBL_HI = 1; // upper byte drives y2

endpackage

`default_nettype wire

//--- verilog/cfg_chain.sv
`include "fabric_config.svh"

`default_nettype none

module cfg_chain (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     sin,      // serial configuration data from the host
	input  logic                     shift_en, // one place per edge while high
	input  logic                     cfg_req,  // commit request, four-phase
	output logic                     sout,     // bit falling off the end of the chain
	output logic                     cfg_ack,
	output logic [`FAB_CFG_BITS-1:0] active_cfg
);

	// shadow copy that the host shifts through, the fabric never sees it directly
	logic [`FAB_CFG_BITS-1:0] shadow;

	logic shift_ok; // shift only while no commit is in progress
	logic commit;   // edge on which the shadow is copied over

	assign shift_ok = shift_en & ~cfg_req & ~cfg_ack;
	assign commit   = cfg_req & ~cfg_ack;

	// bit 0 is a flop output, so the host reads it before the edge that drops it
	assign sout = shadow[0];

	// the chain shifts toward bit 0 and sin enters at the top
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			shadow <= '0;
		end else if (shift_ok) begin
			shadow <= {sin, shadow[`FAB_CFG_BITS-1:1]};
		end
	end

	// active configuration the tiles run from
	// all zero after reset so that no pin drives until the first commit
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			active_cfg <= '0;
		end else if (commit) begin
			active_cfg <= shadow; // whole word at once, logic never sees a half-shifted chain
		end
	end

	// four-phase handshake
	// ack rises on the commit edge and holds until req is seen low
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_ack <= 1'b0;
		end else if (commit) begin
			cfg_ack <= 1'b1;
		end else if (!cfg_req) begin
			cfg_ack <= 1'b0; // req dropped, release on this edge
		end
	end

	// while req and ack are both high nothing changes here,
	// the host simply waits for it to let go of req

endmodule

`default_nettype wire

//--- verilog/clb.sv
`default_nettype none

module clb (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic [3:0]             lut_in,    // from the connection box
	input  fabric_pkg::clb_table_u lut_table,
	input  logic                   lut4_mode, // one LUT4 when set, two LUT3 otherwise
	input  logic                   reg_y1,    // take y1 from its flop
	input  logic                   reg_y2,
	output logic                   y1,
	output logic                   y2
);
	import fabric_pkg::*;

	logic y1_comb; // raw lookups ahead of the optional flops
	logic y2_comb;
	logic y1_q;
	logic y2_q;

	// table lookup
	// in dual mode both LUT3 share the low three inputs and lut_in[3] is ignored
	always_comb begin
		if (lut4_mode) begin
			y1_comb = lut_table.lut4[lut_in]; // both outputs carry the same LUT4 result
			y2_comb = lut_table.lut4[lut_in];
		end else begin
			y1_comb = lut_table.halves[TBL_LO][lut_in[2:0]];
			y2_comb = lut_table.halves[TBL_HI][lut_in[2:0]];
		end
	end

	// output flops load on every edge, the register bits only choose
	// which version leaves the block
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			y1_q <= 1'b0;
			y2_q <= 1'b0;
		end else begin
			y1_q <= y1_comb;
			y2_q <= y2_comb;
		end
	end

	assign y1 = reg_y1 ? y1_q : y1_comb; // one cycle of latency when registered
	assign y2 = reg_y2 ? y2_q : y2_comb;

endmodule

`default_nettype wire

//--- verilog/fabric_tile.sv
`include "fabric_config.svh"

`default_nettype none

module fabric_tile (
	input  logic                          sys_clk,
	input  logic                          rst_n,
	input  logic [`FAB_TRACKS-1:0]        trk_in,    // outgoing tracks of the left neighbor
	input  logic [`FAB_TILE_BITS-1:0]     tile_cfg,  // this tile's slice of the active word
	input  fabric_pkg::clb_table_u        lut_table,
	input  logic [`FAB_PINS_PER_TILE-1:0] pin_in,
	output logic [`FAB_TRACKS-1:0]        trk_out,   // toward the right neighbor
	output logic [`FAB_PINS_PER_TILE-1:0] pin_out,
	output logic [`FAB_PINS_PER_TILE-1:0] pin_oe
);

	logic [3:0] clb_in; // the four inputs picked by the connection box
	logic       y1;
	logic       y2;

	// connection box
	// each CLB input names one incoming track with its two select bits
	for (genvar i = 0; i < 4; i++) begin : g_cb
		logic [1:0] sel;

		assign sel       = tile_cfg[`CFG_CB_LSB + 2*i +: 2];
		assign clb_in[i] = trk_in[sel];
	end

	clb i_clb (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.lut_in    (clb_in),
		.lut_table (lut_table),
		.lut4_mode (tile_cfg[`CFG_MODE_BIT]),
		.reg_y1    (tile_cfg[`CFG_REG1_BIT]),
		.reg_y2    (tile_cfg[`CFG_REG2_BIT]),
		.y1        (y1),
		.y2        (y2)
	);

	// switch box
	// an outgoing track carries the same track from the left, a CLB output or a pin,
	// tracks never turn back so no loop can be built
	for (genvar j = 0; j < `FAB_TRACKS; j++) begin : g_sb
		logic [1:0] sel;
		logic       drive; // value placed on outgoing track j

		assign sel = tile_cfg[`CFG_SB_LSB + 2*j +: 2];

		always_comb begin
			case (sel)
				`SB_PASS: drive = trk_in[j];
				`SB_Y1:   drive = y1;
				`SB_Y2:   drive = y2;
				default:  drive = pin_in[j % `FAB_PINS_PER_TILE]; // `SB_PIN, parity picks the pin
			endcase
		end

		assign trk_out[j] = drive;
	end

	// pin block
	// the output side of a pin always follows its selected outgoing track,
	// the oe bit alone decides whether the pad drives
	for (genvar p = 0; p < `FAB_PINS_PER_TILE; p++) begin : g_io
		logic [1:0] trk_sel;

		assign trk_sel    = tile_cfg[`CFG_IO_LSB + 3*p + 1 +: 2];
		assign pin_oe[p]  = tile_cfg[`CFG_IO_LSB + 3*p];
		assign pin_out[p] = trk_out[trk_sel];
	end

	// the table field of tile_cfg is not sliced here,
	// it comes in already typed on lut_table

endmodule

`default_nettype wire

//--- verilog/fabric_top.sv
`include "fabric_config.svh"

`default_nettype none

module fabric_top (
	input  logic                 sys_clk,
	input  logic                 rst_n,
	input  logic                 sin,      // configuration chain in
	input  logic                 shift_en,
	input  logic                 cfg_req,
	input  logic [`FAB_PINS-1:0] pin_in,
	output logic                 sout,     // configuration chain out, for readback
	output logic                 cfg_ack,
	output logic [`FAB_PINS-1:0] pin_out,
	output logic [`FAB_PINS-1:0] pin_oe
);
	import fabric_pkg::*;

	logic [`FAB_CFG_BITS-1:0] active_cfg; // committed configuration of all tiles

	// trk[t] enters tile t and trk[t+1] leaves it along the routing channel
	logic [`FAB_TILES:0][`FAB_TRACKS-1:0] trk;

	assign trk[0] = '0; // nothing to the left of tile 0

	cfg_chain i_cfg_chain (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.sin        (sin),
		.shift_en   (shift_en),
		.cfg_req    (cfg_req),
		.sout       (sout),
		.cfg_ack    (cfg_ack),
		.active_cfg (active_cfg)
	);

	// tile t owns bits t*41 up to t*41+40 of the active word and pins 2t, 2t+1
	for (genvar t = 0; t < `FAB_TILES; t++) begin : g_tile
		clb_table_u tile_table; // truth table field seen through the union

		assign tile_table = active_cfg[t*`FAB_TILE_BITS + `CFG_TABLE_LSB +: `CFG_TABLE_W];

		fabric_tile i_fabric_tile (
			.sys_clk   (sys_clk),
			.rst_n     (rst_n),
			.trk_in    (trk[t]),
			.tile_cfg  (active_cfg[t*`FAB_TILE_BITS +: `FAB_TILE_BITS]),
			.lut_table (tile_table),
			.pin_in    (pin_in[t*`FAB_PINS_PER_TILE +: `FAB_PINS_PER_TILE]),
			.trk_out   (trk[t+1]),
			.pin_out   (pin_out[t*`FAB_PINS_PER_TILE +: `FAB_PINS_PER_TILE]),
			.pin_oe    (pin_oe[t*`FAB_PINS_PER_TILE +: `FAB_PINS_PER_TILE])
		);
	end

	// the tracks leaving the last tile end at the edge of the fabric,
	// they only reach the outside through that tile's own pins

endmodule

`default_nettype wire

//--- dv/fabric_tests.svh
`ifndef FABRIC_TESTS_SVH
`define FABRIC_TESTS_SVH

logic [`FAB_CFG_BITS-1:0] cfg_vec; // configuration being assembled for the next load

// CLB input i of a tile reads incoming track sel through the connection box
task automatic set_cb(input int tile, input int i, input logic [1:0] sel);
	cfg_vec[tile*`FAB_TILE_BITS + `CFG_CB_LSB + 2*i +: 2] = sel;
endtask

task automatic set_sb(input int tile, input int j, input logic [1:0] code);
	cfg_vec[tile*`FAB_TILE_BITS + `CFG_SB_LSB + 2*j +: 2] = code;
endtask

// pin p of a tile gets its oe bit and then the outgoing track it shows
task automatic set_pin(input int tile, input int p, input logic oe, input logic [1:0] trk);
	int base;
	base = tile*`FAB_TILE_BITS + `CFG_IO_LSB + 3*p;
	cfg_vec[base]        = oe;
	cfg_vec[base+1 +: 2] = trk;
endtask

task automatic set_clb(input int tile, input logic lut4, input logic r1, input logic r2,
		input logic [15:0] tbl);
	int base;
	base = tile*`FAB_TILE_BITS;
	cfg_vec[base + `CFG_MODE_BIT]            = lut4;
	cfg_vec[base + `CFG_REG1_BIT]            = r1;
	cfg_vec[base + `CFG_REG2_BIT]            = r2;
	cfg_vec[base + `CFG_TABLE_LSB +: 16]     = tbl;
endtask

task automatic test_reset_state();
	check_bit(|pin_oe, 1'b0, "pin_oe after reset");
	check_bit(cfg_ack, 1'b0, "cfg_ack after reset");
	check_bit(sout, 1'b0, "sout after reset");
endtask

// a second vector pushes the first one out on sout while nothing reaches the fabric
task automatic test_readback();
	logic [CFG_N-1:0] first;
	logic [CFG_N-1:0] second;
	first  = random_vector();
	second = random_vector();
	shift_vector(first, '0, 1'b1, 1'b1); // the chain still holds its reset zeros
	shift_vector(second, first, 1'b1, 1'b1);
endtask

task automatic test_commit_handshake();
	logic [CFG_N-1:0] vec;
	logic [CFG_N-1:0] junk;
	vec  = random_vector();
	junk = random_vector();
	shift_vector(vec, '0, 1'b0, 1'b0);
	cfg_req = 1'b1;
	wait_ack(1'b1, "raising cfg_req");
	for (int t = 0; t < `FAB_TILES; t++) begin
		for (int p = 0; p < `FAB_PINS_PER_TILE; p++) begin
			check_bit(pin_oe[2*t+p], vec[t*`FAB_TILE_BITS + `CFG_IO_LSB + 3*p],
				"pin_oe from the committed word");
		end
	end
	// ack holds while req stays high and shift_en has no effect meanwhile
	for (int n = 0; n < 8; n++) begin
		shift_en = 1'b1;
		sin      = junk[n];
		#SETTLE;
		check_bit(cfg_ack, 1'b1, "cfg_ack while cfg_req held");
		step();
	end
	cfg_req = 1'b0; // shift_en stays high on the edge that releases ack
	wait_ack(1'b0, "dropping cfg_req");
	shift_en = 1'b0;
	sin      = 1'b0;
	shift_vector('0, vec, 1'b1, 1'b0); // chain must come back unchanged
endtask

// tile 1 computes XOR on y1 and AND on y2 from pins 0 and 1
task automatic test_dual_lut3();
	logic [7:0] xor_tbl;
	logic [7:0] and_tbl;
	for (int k = 0; k < 8; k++) begin
		xor_tbl[k] = k[0] ^ k[1];
		and_tbl[k] = k[0] & k[1];
	end
	cfg_vec = '0;
	set_sb(0, 0, `SB_PIN);
	set_sb(0, 1, `SB_PIN);
	set_cb(1, 0, 2'd0);
	set_cb(1, 1, 2'd1);
	set_cb(1, 2, 2'd2); // tracks 2 and 3 stay low
	set_cb(1, 3, 2'd3);
	set_clb(1, 1'b0, 1'b0, 1'b0, {and_tbl, xor_tbl});
	set_sb(1, 0, `SB_Y1);
	set_sb(1, 1, `SB_Y2);
	set_pin(1, 0, 1'b1, 2'd0);
	set_pin(1, 1, 1'b1, 2'd1);
	load_config(cfg_vec);
	for (int v = 0; v < 4; v++) begin
		pin_in    = '0;
		pin_in[0] = v[0];
		pin_in[1] = v[1];
		#SETTLE;
		check_bit(pin_out[2], v[0] ^ v[1], "XOR LUT3 on pin 2");
		check_bit(pin_out[3], v[0] & v[1], "AND LUT3 on pin 3");
		check_bit(pin_oe[2] & pin_oe[3], 1'b1, "pin_oe on pins 2 and 3");
		step();
	end
endtask

// pins 0 to 3 feed tile 2 with y1 registered on pin 4 and y2 direct on pin 5
task automatic test_registered_lut4();
	logic [31:0] r;
	logic [15:0] tbl;
	logic [3:0]  prev;
	logic [3:0]  cur;
	r       = $urandom();
	tbl     = r[15:0];
	cfg_vec = '0;
	set_sb(0, 0, `SB_PIN);
	set_sb(0, 1, `SB_PIN);
	set_sb(1, 2, `SB_PIN);
	set_sb(1, 3, `SB_PIN);
	for (int i = 0; i < 4; i++) begin
		set_cb(2, i, i[1:0]);
	end
	set_clb(2, 1'b1, 1'b1, 1'b0, tbl);
	set_sb(2, 0, `SB_Y1);
	set_sb(2, 1, `SB_Y2);
	set_pin(2, 0, 1'b1, 2'd0);
	set_pin(2, 1, 1'b1, 2'd1);
	load_config(cfg_vec);
	r           = $urandom();
	prev        = r[3:0];
	pin_in[3:0] = prev;
	step(); // the flop now holds the lookup of prev
	repeat (24) begin
		r           = $urandom();
		cur         = r[3:0];
		pin_in[3:0] = cur;
		#SETTLE;
		check_bit(pin_out[4], tbl[prev], "registered LUT4 on pin 4");
		check_bit(pin_out[5], tbl[cur], "direct LUT4 on pin 5");
		prev = cur;
		step();
	end
endtask

// pin 0 enters track 2 in tile 0 and is passed along to pin 6 of tile 3
task automatic test_pass_through();
	logic [31:0] r;
	cfg_vec = '0;
	set_sb(0, 2, `SB_PIN);
	for (int t = 1; t < `FAB_TILES; t++) begin
		set_sb(t, 2, `SB_PASS);
	end
	set_pin(3, 0, 1'b1, 2'd2);
	load_config(cfg_vec);
	repeat (16) begin
		r      = $urandom();
		pin_in = r[`FAB_PINS-1:0];
		#SETTLE;
		check_bit(pin_out[6], pin_in[0], "pin 0 routed to pin 6");
		check_bit(pin_oe == 8'h40, 1'b1, "only pin 6 drives");
		step();
	end
endtask

`endif

//--- dv/tb_fabric.sv
`include "fabric_config.svh"

`default_nettype none

module tb_fabric;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CFG_N       = `FAB_CFG_BITS;
	localparam int ACK_TIMEOUT = 20; // cycles allowed for cfg_ack to move
	localparam int SETTLE      = 4;  // from the drive point to the middle of the cycle

	logic                 sys_clk;
	logic                 rst_n;
	logic                 sin;
	logic                 shift_en;
	logic                 cfg_req;
	logic [`FAB_PINS-1:0] pin_in;
	logic                 sout;
	logic                 cfg_ack;
	logic [`FAB_PINS-1:0] pin_out;
	logic [`FAB_PINS-1:0] pin_oe;

	int   errors;   // wrong values seen
	int   checks;
	int   timeouts;
	event timeout_ev; // wakes the block that ends a stuck run

	fabric_top i_fabric_top (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.sin      (sin),
		.shift_en (shift_en),
		.cfg_req  (cfg_req),
		.pin_in   (pin_in),
		.sout     (sout),
		.cfg_ack  (cfg_ack),
		.pin_out  (pin_out),
		.pin_oe   (pin_oe)
	);

	always #4 sys_clk = ~sys_clk; // 8 ns period

	// moves to the drive point, 1 ns after the next rising edge
	task automatic step();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
	endtask

	function automatic logic [CFG_N-1:0] random_vector();
		logic [191:0] wide; // six whole words, the top bits are dropped
		for (int w = 0; w < 6; w++) begin
			wide[w*32 +: 32] = $urandom();
		end
		return wide[CFG_N-1:0];
	endfunction

	// cfg_ack only changes on an edge, so it is polled at the drive point
	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (cfg_ack !== level && n < ACK_TIMEOUT) begin
			step();
			n++;
		end
		if (cfg_ack !== level) begin
			timeouts++;
			$display("timeout at %0t: cfg_ack did not go to %b after %s", $time, level, what);
			-> timeout_ev;
		end
	endtask

	// bit 0 goes first so that it ends up at the bottom of the chain
	task automatic shift_vector(input logic [CFG_N-1:0] vec, input logic [CFG_N-1:0] exp_out,
			input bit check_out, input bit check_oe_off);
		for (int i = 0; i < CFG_N; i++) begin
			shift_en = 1'b1;
			sin      = vec[i];
			if (check_out) begin
				check_bit(sout, exp_out[i], "readback on sout"); // still the bit from before the edge
			end
			if (check_oe_off) begin
				check_bit(|pin_oe, 1'b0, "pin_oe while nothing is committed");
			end
			step();
		end
		shift_en = 1'b0;
		sin      = 1'b0;
	endtask

	// four-phase commit of whatever the chain holds
	task automatic commit_config();
		cfg_req = 1'b1;
		wait_ack(1'b1, "raising cfg_req");
		cfg_req = 1'b0;
		wait_ack(1'b0, "dropping cfg_req");
	endtask

	task automatic load_config(input logic [CFG_N-1:0] vec);
		shift_vector(vec, '0, 1'b0, 1'b0);
		commit_config();
	endtask

	`include "fabric_tests.svh"

	// ends the run as soon as a handshake gets stuck
	initial begin
		@(timeout_ev);
		report_counts();
		$display("Something failed");
		$finish;
	end

	initial begin
		errors   = 0;
		checks   = 0;
		timeouts = 0;
		void'($urandom(32'hf5d019c8));
		sys_clk  = 1'b0;
		rst_n    = 1'b0;
		sin      = 1'b0;
		shift_en = 1'b0;
		cfg_req  = 1'b0;
		pin_in   = '0;
		repeat (16) @(posedge sys_clk);
		#1;
		rst_n = 1'b1;
		step();
		test_reset_state();
		test_readback();
		test_commit_handshake();
		test_dual_lut3();
		test_registered_lut4();
		test_pass_through();
		report_counts();
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
+incdir+dv
verilog/fabric_pkg.sv
verilog/cfg_chain.sv
verilog/clb.sv
verilog/fabric_tile.sv
verilog/fabric_top.sv
dv/tb_fabric.sv

//--- run.sh
#!/bin/sh
# build the fabric with its testbench in Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module tb_fabric -f all.f -o tb_fabric &&
	./obj_dir/tb_fabric > sim.log 2>&1 ||
	{ echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Everything OK" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
